// File: bench/oldland_checker.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_checker
	import oldland_pkg::*;
#(
	parameter int IMEM_WORDS = 128,
	parameter int DMEM_WORDS = 64
) (
	input logic clk,
	input logic reset,
	input logic [31:0] imem_addr,
	input logic [31:0] dmem_addr,
	input logic [31:0] dmem_wdata,
	input logic dmem_wr_en,
	input logic dmem_rd_en,
	input logic [1:0] dmem_width,
	input logic [31:0] prog [IMEM_WORDS],
	input logic [31:0] data_init [DMEM_WORDS],
	output logic done,
	output int error_count,
	output int store_count,
	output int exp_count
);

	localparam int MAX_STORES = 64;
	localparam int MAX_LOADS = 64;
	localparam int MODEL_STEPS = 2000;
	localparam int RESET_LIMIT = 100;
	localparam int STORE_LIMIT = 400;
	localparam int TAIL_CYCLES = 64;

	logic [31:0] exp_addr [MAX_STORES];
	logic [31:0] exp_data [MAX_STORES];
	logic [1:0] exp_width [MAX_STORES];
	logic [31:0] exp_load_addr [MAX_LOADS];
	logic [1:0] exp_load_width [MAX_LOADS];
	int exp_loads;
	int load_count = 0;
	int load_errors = 0;
	logic [31:0] end_pc; // Address of the final branch-to-self.

	function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
			input logic [31:0] b, input logic cin);
		case (op)
		ALU_ADD: return a + b;
		ALU_ADDC: return a + b + {31'b0, cin};
		ALU_SUB: return a - b;
		ALU_SUBC: return a - b + {31'b0, cin};
		ALU_LSL: return a << b[4:0];
		ALU_LSR: return a >> b[4:0];
		ALU_AND: return a & b;
		ALU_XOR: return a ^ b;
		ALU_BIC: return a & ~(32'd1 << b[4:0]);
		ALU_BST: return a | (32'd1 << b[4:0]);
		ALU_OR: return a | b;
		ALU_MOVB: return b;
		ALU_ASR: return 32'($signed(a) >>> b[4:0]);
		ALU_MOVA: return a;
		default: return 32'h0;
		endcase
	endfunction

	function automatic logic cond_met(input logic [2:0] cond, input logic z, input logic c);
		case (cond)
		COND_NE: return !z;
		COND_EQ: return z;
		COND_GEU: return !c;
		COND_LTU: return c;
		COND_ALWAYS: return 1'b1;
		default: return 1'b0;
		endcase
	endfunction

	// Loads take the addressed lane and zero-extend it.
	function automatic logic [31:0] lane_read(input logic [31:0] word, input logic [1:0] lane,
			input logic [1:0] width);
		logic [31:0] s;
		s = word >> (8 * lane);
		case (width)
		WIDTH_BYTE: return {24'h0, s[7:0]};
		WIDTH_HALF: return {16'h0, s[15:0]};
		default: return word;
		endcase
	endfunction

	function automatic logic [31:0] lane_write(input logic [31:0] old, input logic [31:0] data,
			input logic [1:0] lane, input logic [1:0] width);
		logic [31:0] mask;
		case (width)
		WIDTH_BYTE: mask = 32'h0000_00ff << (8 * lane);
		WIDTH_HALF: mask = 32'h0000_ffff << (8 * lane);
		default: mask = 32'hffff_ffff;
		endcase
		return (old & ~mask) | ((data << (8 * lane)) & mask);
	endfunction

	// **********************************************************************
	// Instruction-set model, run once in program order
	// **********************************************************************
	task automatic run_model();
		logic [31:0] regs [NUM_REGS];
		logic [31:0] mem [DMEM_WORDS];
		logic [31:0] w, a, b, imm, addr, pc, target;
		logic [3:0] opc;
		logic [1:0] cls;
		logic [2:0] rd, ra, rb;
		logic z, c, taken, finished;
		int steps;
		for (int k = 0; k < DMEM_WORDS; k++)
			mem[k] = data_init[k];
		for (int k = 0; k < NUM_REGS; k++)
			regs[k] = 32'h0;
		z = 1'b0;
		c = 1'b0;
		pc = RESET_PC;
		finished = 1'b0;
		steps = 0;
		exp_count = 0;
		exp_loads = 0;
		while (!finished && steps < MODEL_STEPS) begin
			w = prog[(pc >> 2) % IMEM_WORDS];
			opc = w[31:28];
			cls = w[27:26];
			rd = w[25:23];
			ra = w[22:20];
			rb = w[19:17];
			imm = {{16{w[19]}}, w[19:4]};
			steps++;
			case (cls)
			CLASS_ARITH: begin
				a = regs[ra];
				b = w[0] ? imm : regs[rb];
				if (opc == ALU_CMP) begin
					z = a == b;
					c = a < b; // Carry holds the borrow.
				end else begin
					regs[rd] = alu_model(opc, a, b, c);
				end
				pc = pc + 32'd4;
			end
			CLASS_BRANCH: begin
				if (opc[0])
					regs[7] = pc + 32'd4; // Calls link the return address.
				taken = opc[0] || cond_met(rd, z, c);
				target = pc + 32'd4 + imm;
				if (taken && target == pc) begin
					finished = 1'b1;
					end_pc = pc;
				end
				pc = taken ? target : pc + 32'd4;
			end
			CLASS_MEM: begin
				addr = regs[ra] + imm;
				if (opc[3]) begin
					if (exp_count < MAX_STORES) begin
						exp_addr[exp_count] = addr;
						exp_data[exp_count] = regs[rd];
						exp_width[exp_count] = opc[1:0];
						exp_count++;
					end
					mem[(addr >> 2) % DMEM_WORDS] = lane_write(mem[(addr >> 2) % DMEM_WORDS],
						regs[rd], addr[1:0], opc[1:0]);
				end else begin
					if (exp_loads < MAX_LOADS) begin
						exp_load_addr[exp_loads] = addr;
						exp_load_width[exp_loads] = opc[1:0];
						exp_loads++;
					end
					regs[rd] = lane_read(mem[(addr >> 2) % DMEM_WORDS], addr[1:0], opc[1:0]);
				end
				pc = pc + 32'd4;
			end
			default: pc = pc + 32'd4;
			endcase
		end
		if (!finished) begin
			$display("Model did not reach the final branch loop within %0d steps", steps);
			error_count++;
		end
	endtask

	// Each read strobe belongs to the next load in program order.
	always @(posedge clk) begin
		if (dmem_rd_en === 1'b1) begin
			if (load_count >= exp_loads) begin
				$display("Unexpected load from address %h beyond the %0d expected loads",
					dmem_addr, exp_loads);
				load_errors++;
			end else begin
				if (dmem_addr !== exp_load_addr[load_count]) begin
					$display("Mismatch load %0d dmem_addr: expected %h, got %h", load_count,
						exp_load_addr[load_count], dmem_addr);
					load_errors++;
				end
				if (dmem_width !== exp_load_width[load_count]) begin
					$display("Mismatch load %0d dmem_width: expected %h, got %h", load_count,
						exp_load_width[load_count], dmem_width);
					load_errors++;
				end
			end
			load_count++;
		end
	end

	initial begin
		int cycles;
		int i;
		logic found, seen_loop, stuck;
		done = 1'b0;
		error_count = 0;
		store_count = 0;
		exp_count = 0;
		end_pc = 32'hffff_ffff;
		stuck = 1'b0;
		cycles = 0;
		while (reset !== 1'b0 && cycles < RESET_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (reset !== 1'b0) begin
			$display("Reset was never released within %0d cycles", RESET_LIMIT);
			error_count++;
			stuck = 1'b1;
		end
		run_model();
		for (i = 0; i < exp_count && !stuck; i++) begin
			found = 1'b0;
			cycles = 0;
			while (!found && cycles < STORE_LIMIT) begin
				@(posedge clk);
				cycles++;
				found = dmem_wr_en === 1'b1;
			end
			if (!found) begin
				$display("Timed out waiting for store %0d of %0d", i, exp_count);
				error_count++;
				stuck = 1'b1;
			end else begin
				store_count++;
				if (dmem_addr !== exp_addr[i]) begin
					$display("Mismatch store %0d dmem_addr: expected %h, got %h", i,
						exp_addr[i], dmem_addr);
					error_count++;
				end
				if (dmem_wdata !== exp_data[i]) begin
					$display("Mismatch store %0d dmem_wdata: expected %h, got %h", i,
						exp_data[i], dmem_wdata);
					error_count++;
				end
				if (dmem_width !== exp_width[i]) begin
					$display("Mismatch store %0d dmem_width: expected %h, got %h", i,
						exp_width[i], dmem_width);
					error_count++;
				end
			end
		end
		// After the last store only the branch-to-self should run.
		seen_loop = 1'b0;
		for (cycles = 0; cycles < TAIL_CYCLES && !stuck; cycles++) begin
			@(posedge clk);
			if (dmem_wr_en === 1'b1) begin
				$display("Unexpected extra store to address %h after the last expected store",
					dmem_addr);
				error_count++;
			end
			if (imem_addr === end_pc)
				seen_loop = 1'b1;
		end
		if (!stuck && !seen_loop) begin
			$display("Fetch never reached the final branch loop at %h", end_pc);
			error_count++;
		end
		if (!stuck && load_count != exp_loads) begin
			$display("Saw %0d loads but the program executes %0d", load_count, exp_loads);
			error_count++;
		end
		error_count = error_count + load_errors;
		done = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/oldland_tb.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_tb
	import oldland_pkg::*;
();

	localparam int IMEM_WORDS = 128;
	localparam int DMEM_WORDS = 64;
	localparam int PROG_START = 8; // Words before this load the registers.
	localparam int PROG_END = PROG_START + 48;
	localparam int DONE_LIMIT = 20000;

	logic clk;
	logic reset;
	logic [31:0] imem_data;
	logic [31:0] dmem_rdata;
	logic [31:0] imem_addr;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic dmem_wr_en;
	logic dmem_rd_en;
	logic [1:0] dmem_width;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] data_init [DMEM_WORDS];
	logic [31:0] rng;
	logic checker_done;
	int checker_errors;
	int stores_seen;
	int stores_expected;
	int total_errors;
	int cycles;

	oldland_cpu i_dut (
		.clk(clk), .reset(reset), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
		.imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
		.dmem_wr_en(dmem_wr_en), .dmem_rd_en(dmem_rd_en), .dmem_width(dmem_width)
	);

	oldland_checker #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) i_checker (
		.clk(clk), .reset(reset), .imem_addr(imem_addr), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_wr_en(dmem_wr_en), .dmem_rd_en(dmem_rd_en),
		.dmem_width(dmem_width), .prog(imem), .data_init(data_init), .done(checker_done),
		.error_count(checker_errors), .store_count(stores_seen),
		.exp_count(stores_expected)
	);

	// **********************************************************************
	// Random program generation
	// **********************************************************************

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned pick(input int unsigned n);
		rng = xorshift32(rng);
		return rng % n;
	endfunction

	function automatic logic [31:0] reg_form(input logic [3:0] opc, input logic [1:0] cls,
			input logic [2:0] rd, input logic [2:0] ra, input logic [2:0] rb);
		return {opc, cls, rd, ra, rb, 16'h0000, 1'b0};
	endfunction

	function automatic logic [31:0] imm_form(input logic [3:0] opc, input logic [1:0] cls,
			input logic [2:0] rd, input logic [2:0] ra, input logic [15:0] imm);
		return {opc, cls, rd, ra, imm, 3'b000, 1'b1};
	endfunction

	function automatic logic [2:0] dest_reg();
		logic [2:0] r;
		r = 3'(pick(7));
		return (r == 3'd6) ? 3'd7 : r; // r6 stays the data window base.
	endfunction

	function automatic logic [3:0] random_alu_op();
		int n;
		n = pick(15);
		return (n >= 13) ? 4'(n + 1) : 4'(n); // Opcode 13 has no operation.
	endfunction

	function automatic logic [2:0] random_cond();
		case (pick(6))
		0: return COND_NEVER;
		1: return COND_NE;
		2: return COND_EQ;
		3: return COND_GEU;
		4: return COND_LTU;
		default: return COND_ALWAYS;
		endcase
	endfunction

	task automatic build_program();
		int i;
		int kind;
		int width;
		int off;
		int skip;
		logic store;
		logic [3:0] opc;
		logic [2:0] rd, ra, rb;
		logic [15:0] imm;
		for (i = 0; i < IMEM_WORDS; i++)
			imem[i] = 32'h0;
		for (i = 0; i < NUM_REGS; i++) begin
			imm = (i == 6) ? 16'h0080 : 16'(pick(65536));
			imem[i] = imm_form(ALU_MOVB, CLASS_ARITH, 3'(i), 3'd0, imm);
		end
		for (i = PROG_START; i < PROG_END; i++) begin
			kind = pick(10);
			if (kind < 5) begin
				opc = random_alu_op();
				rd = dest_reg();
				ra = 3'(pick(8));
				if (pick(2) == 1) begin
					imm = 16'(pick(65536));
					imem[i] = imm_form(opc, CLASS_ARITH, rd, ra, imm);
				end else begin
					rb = 3'(pick(8));
					imem[i] = reg_form(opc, CLASS_ARITH, rd, ra, rb);
				end
			end else if (kind < 7) begin
				width = pick(3);
				off = int'(pick(256)) - 128;
				off = off & ~((1 << width) - 1); // Natural alignment.
				store = pick(2) == 1;
				if (store)
					rd = 3'(pick(8));
				else
					rd = dest_reg();
				imem[i] = imm_form({store, 1'b0, 2'(width)}, CLASS_MEM, rd, 3'd6, 16'(off));
			end else begin
				skip = pick((PROG_END - i < 4) ? PROG_END - i : 4); // Forward only.
				rd = random_cond();
				opc = {3'b000, kind == 9}; // Low opcode bit marks a call.
				imem[i] = imm_form(opc, CLASS_BRANCH, rd, 3'd0, 16'(skip * 4));
			end
		end
		for (i = 0; i < NUM_REGS; i++)
			imem[PROG_END + i] = imm_form({1'b1, 1'b0, WIDTH_WORD}, CLASS_MEM, 3'(i), 3'd6,
				16'(4 * i - 128));
		imem[PROG_END + NUM_REGS] = imm_form(4'b0000, CLASS_BRANCH, COND_ALWAYS, 3'd0, 16'hfffc);
	endtask

	// **********************************************************************
	// Memories
	// **********************************************************************

	function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] data,
			input logic [1:0] lane, input logic [1:0] width);
		logic [31:0] mask;
		case (width)
		WIDTH_BYTE: mask = 32'h0000_00ff << (8 * lane);
		WIDTH_HALF: mask = 32'h0000_ffff << (8 * lane);
		default: mask = 32'hffff_ffff;
		endcase
		return (old & ~mask) | ((data << (8 * lane)) & mask);
	endfunction

	always @(posedge clk) begin
		imem_data <= imem[imem_addr[8:2]];
		dmem_rdata <= dmem[dmem_addr[7:2]];
		if (dmem_wr_en)
			dmem[dmem_addr[7:2]] <= merge_store(dmem[dmem_addr[7:2]], dmem_wdata,
				dmem_addr[1:0], dmem_width);
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		reset <= 1'b1;
		imem_data <= 32'h0;
		dmem_rdata <= 32'h0;
		rng = 32'd47;
		build_program();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			rng = xorshift32(rng);
			data_init[i] = rng;
			dmem[i] <= rng;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (!checker_done && cycles < DONE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		total_errors = checker_errors;
		if (!checker_done) begin
			$display("Timed out after %0d cycles waiting for the checker to finish", cycles);
			total_errors++;
		end
		$display("Stores checked: %0d of %0d, errors: %0d", stores_seen, stores_expected,
			total_errors);
		if (total_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/oldland_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_cpu (
	input logic clk,
	input logic reset,
	input logic [31:0] imem_data,
	input logic [31:0] dmem_rdata,
	output logic [31:0] imem_addr,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic dmem_wr_en,
	output logic dmem_rd_en,
	output logic [1:0] dmem_width
);

	logic hold, fetch_valid, branch_taken, stall_clear;
	logic [31:0] fetch_pc_plus_4, alu_out;
	logic [2:0] ra_sel, rb_sel;
	logic [31:0] rf_ra, rf_rb;
	logic [31:0] ex_ra, ex_rb, imm32, ex_pc_plus_4;
	logic [2:0] rd_sel;
	logic update_rd, alu_op1_ra, alu_op2_rb, mem_load, mem_store;
	logic [3:0] alu_opc;
	logic [1:0] mem_width;
	logic [2:0] branch_condition;
	logic [1:0] instr_class;
	logic is_call, update_flags;
	logic [31:0] wr_val;
	logic wr_result;
	logic [2:0] rd_sel_out;
	logic reg_wr_en;
	logic [2:0] reg_wr_sel;
	logic [31:0] reg_wr_val;

	oldland_fetch i_fetch (
		.clk(clk), .reset(reset), .hold(hold), .branch_taken(branch_taken),
		.branch_target(alu_out), .imem_addr(imem_addr), .fetch_valid(fetch_valid),
		.pc_plus_4(fetch_pc_plus_4)
	);

	oldland_decode i_decode (
		.clk(clk), .reset(reset), .fetch_valid(fetch_valid), .instr(imem_data),
		.pc_plus_4_in(fetch_pc_plus_4), .stall_clear(stall_clear),
		.reg_wr_en(reg_wr_en), .reg_wr_sel(reg_wr_sel),
		.ra_data(rf_ra), .rb_data(rf_rb), .hold(hold),
		.ra_sel(ra_sel), .rb_sel(rb_sel), .ra(ex_ra), .rb(ex_rb), .imm32(imm32),
		.pc_plus_4(ex_pc_plus_4), .rd_sel(rd_sel), .update_rd(update_rd),
		.alu_opc(alu_opc), .alu_op1_ra(alu_op1_ra), .alu_op2_rb(alu_op2_rb),
		.mem_load(mem_load), .mem_store(mem_store), .mem_width(mem_width),
		.branch_condition(branch_condition), .instr_class(instr_class),
		.is_call(is_call), .update_flags(update_flags)
	);

	oldland_regfile i_regfile (
		.clk(clk), .ra_sel(ra_sel), .rb_sel(rb_sel), .wr_en(reg_wr_en),
		.wr_sel(reg_wr_sel), .wr_val(reg_wr_val), .ra(rf_ra), .rb(rf_rb)
	);

	// The memory request registers in exec drive the data port directly.
	oldland_exec i_exec (
		.clk(clk), .reset(reset), .ra(ex_ra), .rb(ex_rb), .imm32(imm32),
		.pc_plus_4(ex_pc_plus_4), .rd_sel(rd_sel), .update_rd(update_rd),
		.alu_opc(alu_opc), .alu_op1_ra(alu_op1_ra), .alu_op2_rb(alu_op2_rb),
		.mem_load(mem_load), .mem_store(mem_store), .mem_width(mem_width),
		.branch_condition(branch_condition), .instr_class(instr_class),
		.is_call(is_call), .update_flags(update_flags),
		.branch_taken(branch_taken), .alu_out(alu_out), .mem_load_out(dmem_rd_en),
		.mem_store_out(), .mem_width_out(dmem_width), .wr_val(wr_val),
		.wr_result(wr_result), .rd_sel_out(rd_sel_out), .stall_clear(stall_clear),
		.mar(dmem_addr), .mdr(dmem_wdata), .mem_wr_en(dmem_wr_en)
	);

	oldland_memory i_memory (
		.clk(clk), .reset(reset), .mem_load(dmem_rd_en), .mem_width(dmem_width),
		.mar_low(dmem_addr[1:0]), .dmem_rdata(dmem_rdata), .wr_result(wr_result),
		.rd_sel(rd_sel_out), .wr_val(wr_val), .reg_wr_en(reg_wr_en),
		.reg_wr_sel(reg_wr_sel), .reg_wr_val(reg_wr_val)
	);

endmodule

`default_nettype wire

// File: hdl/oldland_decode.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_decode
	import oldland_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic fetch_valid,
	input instr_t instr,
	input logic [31:0] pc_plus_4_in,
	input logic stall_clear,
	input logic reg_wr_en,
	input logic [2:0] reg_wr_sel,
	input logic [31:0] ra_data,
	input logic [31:0] rb_data,
	output logic hold,
	output logic [2:0] ra_sel,
	output logic [2:0] rb_sel,
	output logic [31:0] ra,
	output logic [31:0] rb,
	output logic [31:0] imm32,
	output logic [31:0] pc_plus_4,
	output logic [2:0] rd_sel,
	output logic update_rd,
	output logic [3:0] alu_opc,
	output logic alu_op1_ra,
	output logic alu_op2_rb,
	output logic mem_load,
	output logic mem_store,
	output logic [1:0] mem_width,
	output logic [2:0] branch_condition,
	output logic [1:0] instr_class,
	output logic is_call,
	output logic update_flags
);

	logic [NUM_REGS-1:0] pending;
	logic [NUM_REGS-1:0] set_mask;
	logic [NUM_REGS-1:0] clr_mask;
	logic branch_pending;
	logic load_last;
	logic d_op1_ra, d_op2_rb, d_update_rd, d_flags;
	logic d_load, d_store, d_call;
	logic uses_ra, uses_rb;
	logic [3:0] d_alu;
	logic [2:0] d_rd, d_cond;
	logic [1:0] d_width;
	logic stall, issue;

	always_comb begin
		d_alu = ALU_ADD;
		d_op1_ra = 1'b1;
		d_op2_rb = 1'b0;
		d_update_rd = 1'b0;
		d_flags = 1'b0;
		d_load = 1'b0;
		d_store = 1'b0;
		d_call = 1'b0;
		d_cond = COND_NEVER;
		d_rd = instr.r.rd;
		d_width = instr.r.opcode[1:0];
		uses_ra = 1'b0;
		uses_rb = 1'b0;
		case (instr.r.cls)
		CLASS_ARITH: begin
			d_alu = instr.r.opcode;
			d_op2_rb = !instr.r.imm_sel;
			d_update_rd = instr.r.opcode != ALU_CMP;
			d_flags = instr.r.opcode == ALU_CMP;
			uses_ra = 1'b1;
			uses_rb = !instr.r.imm_sel;
		end
		CLASS_BRANCH: begin
			// Target is pc_plus_4 + imm32; rd carries the condition.
			d_op1_ra = 1'b0;
			d_call = instr.r.opcode[0];
			d_cond = d_call ? COND_ALWAYS : instr.r.rd;
			d_update_rd = d_call;
			if (d_call)
				d_rd = 3'd7; // Link register.
		end
		CLASS_MEM: begin
			d_store = instr.r.opcode[3];
			d_load = !instr.r.opcode[3];
			d_update_rd = !instr.r.opcode[3];
			uses_ra = 1'b1;
			uses_rb = instr.r.opcode[3];
		end
		default: ;
		endcase
	end

	assign ra_sel = instr.r.ra;
	assign rb_sel = d_store ? instr.r.rd : instr.r.rb; // Store data sits in the rd field.

	// A write issued right after a load would share the load's write-back cycle.
	assign stall = branch_pending
		|| (uses_ra && pending[ra_sel])
		|| (uses_rb && pending[rb_sel])
		|| (d_update_rd && pending[d_rd])
		|| (d_update_rd && !d_load && load_last);
	assign hold = fetch_valid && stall;
	assign issue = fetch_valid && !stall;

	assign set_mask = (issue && d_update_rd) ? {{(NUM_REGS-1){1'b0}}, 1'b1} << d_rd : '0;
	assign clr_mask = reg_wr_en ? {{(NUM_REGS-1){1'b0}}, 1'b1} << reg_wr_sel : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
			branch_pending <= 1'b0;
			load_last <= 1'b0;
			update_rd <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			is_call <= 1'b0;
			update_flags <= 1'b0;
			branch_condition <= COND_NEVER;
			instr_class <= CLASS_MISC;
		end else begin
			pending <= (pending & ~clr_mask) | set_mask; // A new issue wins over a clear.
			if (stall_clear)
				branch_pending <= 1'b0;
			else if (issue && instr.r.cls == CLASS_BRANCH)
				branch_pending <= 1'b1;
			load_last <= issue && d_load;
			update_rd <= issue && d_update_rd;
			mem_load <= issue && d_load;
			mem_store <= issue && d_store;
			is_call <= issue && d_call;
			update_flags <= issue && d_flags;
			branch_condition <= issue ? d_cond : COND_NEVER;
			instr_class <= issue ? instr.r.cls : CLASS_MISC;
		end
	end

	always_ff @(posedge clk) begin
		ra <= ra_data;
		rb <= rb_data;
		imm32 <= {{16{instr.i.imm16[15]}}, instr.i.imm16};
		pc_plus_4 <= pc_plus_4_in;
		rd_sel <= d_rd;
		alu_opc <= d_alu;
		alu_op1_ra <= d_op1_ra;
		alu_op2_rb <= d_op2_rb;
		mem_width <= d_width;
	end

endmodule

`default_nettype wire

// File: hdl/oldland_exec.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_exec
	import oldland_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [31:0] ra,
	input logic [31:0] rb,
	input logic [31:0] imm32,
	input logic [31:0] pc_plus_4,
	input logic [2:0] rd_sel,
	input logic update_rd,
	input logic [3:0] alu_opc,
	input logic alu_op1_ra,
	input logic alu_op2_rb,
	input logic mem_load,
	input logic mem_store,
	input logic [1:0] mem_width,
	input logic [2:0] branch_condition,
	input logic [1:0] instr_class,
	input logic is_call,
	input logic update_flags,
	output logic branch_taken,
	output logic [31:0] alu_out,
	output logic mem_load_out,
	output logic mem_store_out,
	output logic [1:0] mem_width_out,
	output logic [31:0] wr_val,
	output logic wr_result,
	output logic [2:0] rd_sel_out,
	output logic stall_clear,
	output logic [31:0] mar,
	output logic [31:0] mdr,
	output logic mem_wr_en
);

	logic [31:0] op1, op2, alu_q;
	logic alu_c, alu_z, cond_met;
	logic z_flag, c_flag; // Hidden status flags.

	assign op1 = alu_op1_ra ? ra : pc_plus_4;
	assign op2 = alu_op2_rb ? rb : imm32;
	assign alu_z = op1 == op2;

	// **********************************************************************
	// ALU
	// **********************************************************************
	always_comb begin
		alu_c = 1'b0;
		case (alu_opc)
		ALU_ADD: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		ALU_ADDC: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'b0, c_flag};
		ALU_SUB: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_SUBC: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} + {32'b0, c_flag};
		ALU_LSL: {alu_c, alu_q} = {1'b0, op1} << op2[4:0];
		ALU_LSR: alu_q = op1 >> op2[4:0];
		ALU_AND: alu_q = op1 & op2;
		ALU_XOR: alu_q = op1 ^ op2;
		ALU_BIC: alu_q = op1 & ~(32'd1 << op2[4:0]);
		ALU_BST: alu_q = op1 | (32'd1 << op2[4:0]);
		ALU_OR: alu_q = op1 | op2;
		ALU_MOVB: alu_q = op2;
		ALU_CMP: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2}; // Carry is the borrow.
		ALU_ASR: alu_q = $signed(op1) >>> op2[4:0];
		ALU_MOVA: alu_q = op1;
		default: alu_q = 32'b0;
		endcase
	end

	always_comb begin
		case (branch_condition)
		COND_ALWAYS: cond_met = 1'b1;
		COND_NE: cond_met = !z_flag;
		COND_EQ: cond_met = z_flag;
		COND_GEU: cond_met = !c_flag;
		COND_LTU: cond_met = c_flag;
		default: cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			branch_taken <= 1'b0;
			stall_clear <= 1'b0;
			wr_result <= 1'b0;
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			mem_wr_en <= 1'b0;
			z_flag <= 1'b0;
			c_flag <= 1'b0;
		end else begin
			branch_taken <= instr_class == CLASS_BRANCH && cond_met;
			stall_clear <= instr_class == CLASS_BRANCH; // Resolved either way.
			wr_result <= update_rd;
			mem_load_out <= mem_load;
			mem_store_out <= mem_store;
			mem_wr_en <= mem_store;
			if (update_flags) begin
				z_flag <= alu_z;
				c_flag <= alu_c;
			end
		end
	end

	always_ff @(posedge clk) begin
		alu_out <= alu_q;
		rd_sel_out <= rd_sel;
		wr_val <= is_call ? pc_plus_4 : alu_q;
		if (mem_store || mem_load) begin
			mem_width_out <= mem_width;
			mar <= alu_q;
			if (mem_store)
				mdr <= rb;
		end
	end

endmodule

`default_nettype wire

// File: hdl/oldland_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_fetch
	import oldland_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic hold,
	input logic branch_taken,
	input logic [31:0] branch_target,
	output logic [31:0] imem_addr,
	output logic fetch_valid,
	output logic [31:0] pc_plus_4
);

	logic [31:0] pc;

	// While decode holds, the word under decode is read again.
	assign imem_addr = hold ? pc_plus_4 - 32'd4 : pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
			fetch_valid <= 1'b0;
		end else if (branch_taken) begin
			pc <= branch_target;
			fetch_valid <= 1'b0; // The word in flight is off the taken path.
		end else if (!hold) begin
			pc <= pc + 32'd4;
			fetch_valid <= 1'b1;
		end
	end

	// Follows the word that instruction memory returns next cycle.
	always_ff @(posedge clk) begin
		if (!hold)
			pc_plus_4 <= pc + 32'd4;
	end

endmodule

`default_nettype wire

// File: hdl/oldland_memory.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_memory
	import oldland_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic mem_load,
	input logic [1:0] mem_width,
	input logic [1:0] mar_low,
	input logic [31:0] dmem_rdata,
	input logic wr_result,
	input logic [2:0] rd_sel,
	input logic [31:0] wr_val,
	output logic reg_wr_en,
	output logic [2:0] reg_wr_sel,
	output logic [31:0] reg_wr_val
);

	logic load_q;
	logic [1:0] width_q;
	logic [1:0] lane_q;
	logic [2:0] rd_q;
	logic [31:0] shifted, load_data;

	always_ff @(posedge clk) begin
		if (reset)
			load_q <= 1'b0;
		else
			load_q <= mem_load && wr_result;
	end

	always_ff @(posedge clk) begin
		width_q <= mem_width;
		lane_q <= mar_low;
		rd_q <= rd_sel;
	end

	assign shifted = dmem_rdata >> {lane_q, 3'b000};

	always_comb begin
		case (width_q)
		WIDTH_BYTE: load_data = {24'b0, shifted[7:0]};
		WIDTH_HALF: load_data = {16'b0, shifted[15:0]};
		default: load_data = dmem_rdata;
		endcase
	end

	// Loads write back a cycle later than other results.
	assign reg_wr_en = load_q || (wr_result && !mem_load);
	assign reg_wr_sel = load_q ? rd_q : rd_sel;
	assign reg_wr_val = load_q ? load_data : wr_val;

endmodule

`default_nettype wire

// File: hdl/oldland_pkg.sv
`default_nettype none

package oldland_pkg;

	// **********************************************************************
	// Instruction word
	// **********************************************************************

	// Both views share opcode, class, rd and ra. The rb field of the
	// register view sits in the top bits of the immediate.
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [1:0] cls;
			logic [2:0] rd;
			logic [2:0] ra;
			logic [2:0] rb;
			logic [15:0] func;
			logic imm_sel;
		} r;
		struct packed {
			logic [3:0] opcode;
			logic [1:0] cls;
			logic [2:0] rd;
			logic [2:0] ra;
			logic signed [15:0] imm16;
			logic [2:0] spare;
			logic imm_sel;
		} i;
	} instr_t;

	localparam logic [1:0] CLASS_ARITH = 2'b00;
	localparam logic [1:0] CLASS_BRANCH = 2'b01;
	localparam logic [1:0] CLASS_MEM = 2'b10;
	localparam logic [1:0] CLASS_MISC = 2'b11; // Also used for pipeline bubbles.

	// **********************************************************************
	// ALU operations, branch conditions and access widths
	// **********************************************************************

	localparam logic [3:0] ALU_ADD = 4'b0000;
	localparam logic [3:0] ALU_ADDC = 4'b0001;
	localparam logic [3:0] ALU_SUB = 4'b0010;
	localparam logic [3:0] ALU_SUBC = 4'b0011;
	localparam logic [3:0] ALU_LSL = 4'b0100;
	localparam logic [3:0] ALU_LSR = 4'b0101;
	localparam logic [3:0] ALU_AND = 4'b0110;
	localparam logic [3:0] ALU_XOR = 4'b0111;
	localparam logic [3:0] ALU_BIC = 4'b1000;
	localparam logic [3:0] ALU_BST = 4'b1001;
	localparam logic [3:0] ALU_OR = 4'b1010;
	localparam logic [3:0] ALU_MOVB = 4'b1011;
	localparam logic [3:0] ALU_CMP = 4'b1100;
	localparam logic [3:0] ALU_ASR = 4'b1110;
	localparam logic [3:0] ALU_MOVA = 4'b1111;

	localparam logic [2:0] COND_NEVER = 3'b000;
	localparam logic [2:0] COND_NE = 3'b001;
	localparam logic [2:0] COND_EQ = 3'b010;
	localparam logic [2:0] COND_GEU = 3'b011;
	localparam logic [2:0] COND_LTU = 3'b100;
	localparam logic [2:0] COND_ALWAYS = 3'b111;

	localparam logic [1:0] WIDTH_BYTE = 2'b00;
	localparam logic [1:0] WIDTH_HALF = 2'b01;
	localparam logic [1:0] WIDTH_WORD = 2'b10;

	localparam int NUM_REGS = 8;
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hdl/oldland_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module oldland_regfile
	import oldland_pkg::*;
(
	input logic clk,
	input logic [2:0] ra_sel,
	input logic [2:0] rb_sel,
	input logic wr_en,
	input logic [2:0] wr_sel,
	input logic [31:0] wr_val,
	output logic [31:0] ra,
	output logic [31:0] rb
);

	logic [31:0] regs [NUM_REGS];

	// Reads return the value before any write on the same edge.
	assign ra = regs[ra_sel];
	assign rb = regs[rb_sel];

	always_ff @(posedge clk) begin
		if (wr_en)
			regs[wr_sel] <= wr_val;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/oldland_pkg.sv
hdl/oldland_fetch.sv
hdl/oldland_decode.sv
hdl/oldland_regfile.sv
hdl/oldland_exec.sv
hdl/oldland_memory.sv
hdl/oldland_cpu.sv
bench/oldland_checker.sv
bench/oldland_tb.sv
